// File: sq_pkg.sv
package sq_pkg;

    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [29:0] word_addr_t;  // Address of a 32-bit word, byte offset dropped
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;       // One bit per byte lane

    // Default store queue index, sized for 8 entries
    // The packet index fields below carry this width, so deeper queues need it widened
    typedef logic [2:0]  sq_idx_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } st_size_e;

    // AXI4-Lite BRESP codes in use here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Store operands from issue, one per cycle
    typedef struct packed {
        sq_idx_t  index;   // Entry given out at dispatch
        addr_t    base;
        addr_t    offset;
        data_t    data;    // Unaligned, value in the low bytes
        st_size_e size;
    } st_exec_t;

    // Resolved store, written into its queue entry
    typedef struct packed {
        sq_idx_t    index;
        word_addr_t word_addr;
        strb_t      strb;
        data_t      data;  // Already shifted into its lanes
    } sq_fill_t;

    // Committed store at the drain head
    typedef struct packed {
        word_addr_t word_addr;
        strb_t      strb;
        data_t      data;
    } sq_drain_t;

endpackage

// File: store_agu.sv
`timescale 1ns/1ps

module store_agu (
    input  logic             clock,
    input  logic             reset,

    input  logic             exec_valid,
    input  sq_pkg::st_exec_t exec,

    output logic             fill_valid,
    output sq_pkg::sq_fill_t fill
);

    sq_pkg::addr_t eff_addr;
    logic [1:0]    lane;      // Byte offset within the word
    sq_pkg::strb_t strb_c;
    sq_pkg::data_t data_c;

    assign eff_addr = exec.base + exec.offset;
    assign lane     = eff_addr[1:0];

    // Strobes shifted to the lane; bits pushed past lane 3 fall off,
    // so a misaligned half or word keeps only what fits in this word
    always_comb begin
        case (exec.size)
            sq_pkg::SIZE_BYTE: strb_c = 4'b0001 << lane;
            sq_pkg::SIZE_HALF: strb_c = 4'b0011 << lane;
            default:           strb_c = 4'b1111 << lane;
        endcase
    end

    assign data_c = exec.data << {lane, 3'b000};  // Low bytes moved up to the strobed lanes

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= exec_valid;
        end
    end

    // Payload only loads on a valid store
    always_ff @(posedge clock) begin
        if (exec_valid) begin
            fill.index     <= exec.index;
            fill.word_addr <= eff_addr[31:2];
            fill.strb      <= strb_c;
            fill.data      <= data_c;
        end
    end

endmodule

// File: store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter  int SQ_DEPTH = 8,
    localparam int IDX_W    = $clog2(SQ_DEPTH)
) (
    input  logic              clock,
    input  logic              reset,

    // Dispatch
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    output logic [IDX_W-1:0]  sq_tail,

    // Execute
    input  logic              fill_valid,
    input  sq_pkg::sq_fill_t  fill,

    // Retire and branch recovery
    input  logic              retire_valid,
    input  logic              restore_valid,
    input  logic [IDX_W-1:0]  restore_tail,

    // Load lookup
    input  sq_pkg::addr_t     load_addr,
    input  logic [IDX_W-1:0]  load_sq_tail,
    output sq_pkg::data_t     load_fwd_data,
    output sq_pkg::strb_t     load_fwd_mask,

    // Drain to memory
    output logic              drain_valid,
    input  logic              drain_ready,
    output sq_pkg::sq_drain_t drain
);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [IDX_W:0]   cnt_t;  // Extra bit so full and empty differ

    sq_pkg::sq_drain_t entry_q [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] valid, valid_nxt;
    logic [SQ_DEPTH-1:0] filled, filled_nxt;
    logic [SQ_DEPTH-1:0] free_mask;

    idx_t head;         // Oldest entry, next to drain
    idx_t commit_ptr;   // Oldest uncommitted entry
    idx_t tail;
    cnt_t committed_cnt;  // Entries in [head, commit_ptr)
    cnt_t pending_cnt;    // Entries in [commit_ptr, tail)

    idx_t fill_idx;
    idx_t freed_n;
    cnt_t keep_cnt;
    logic fill_ok;
    logic dispatch_fire;
    logic drain_fire;

    assign sq_tail        = tail;
    assign dispatch_ready = (committed_cnt + pending_cnt) != cnt_t'(SQ_DEPTH);
    assign dispatch_fire  = dispatch_valid && dispatch_ready && !restore_valid;  // Restore wins

    assign drain_valid = committed_cnt != '0;
    assign drain       = entry_q[head];
    assign drain_fire  = drain_valid && drain_ready;

    assign fill_idx = idx_t'(fill.index);
    assign fill_ok  = fill_valid && valid[fill_idx];  // Squashed stores are dropped

    // Recovery: entries from restore_tail up to the old tail go away
    assign freed_n  = tail - restore_tail;
    assign keep_cnt = pending_cnt - cnt_t'(freed_n);

    always_comb begin
        idx_t off;
        free_mask = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            off = idx_t'(i) - commit_ptr;  // Age among uncommitted entries
            free_mask[i] = (cnt_t'(off) >= keep_cnt) && (cnt_t'(off) < pending_cnt);
        end
    end

    always_comb begin
        valid_nxt  = valid;
        filled_nxt = filled;
        if (fill_ok) begin
            filled_nxt[fill_idx] = 1'b1;
        end
        if (drain_fire) begin
            valid_nxt[head]  = 1'b0;
            filled_nxt[head] = 1'b0;
        end
        if (dispatch_fire) begin
            valid_nxt[tail]  = 1'b1;
            filled_nxt[tail] = 1'b0;
        end
        if (restore_valid) begin
            valid_nxt  = valid_nxt & ~free_mask;
            filled_nxt = filled_nxt & ~free_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid  <= '0;
            filled <= '0;
        end else begin
            valid  <= valid_nxt;
            filled <= filled_nxt;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_ok) begin
            entry_q[fill_idx].word_addr <= fill.word_addr;
            entry_q[fill_idx].strb      <= fill.strb;
            entry_q[fill_idx].data      <= fill.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head          <= '0;
            commit_ptr    <= '0;
            tail          <= '0;
            committed_cnt <= '0;
            pending_cnt   <= '0;
        end else begin
            if (drain_fire) begin
                head <= head + idx_t'(1);
            end
            if (retire_valid) begin
                commit_ptr <= commit_ptr + idx_t'(1);
            end
            committed_cnt <= committed_cnt + cnt_t'(retire_valid) - cnt_t'(drain_fire);
            if (restore_valid) begin
                tail        <= restore_tail;
                pending_cnt <= keep_cnt - cnt_t'(retire_valid);
            end else begin
                if (dispatch_fire) begin
                    tail <= tail + idx_t'(1);
                end
                pending_cnt <= pending_cnt + cnt_t'(dispatch_fire) - cnt_t'(retire_valid);
            end
        end
    end

    // Forwarding, youngest older store first; each lane takes its first hit
    always_comb begin
        idx_t          idx;
        idx_t          age;
        idx_t          load_pos;
        sq_pkg::strb_t hit;
        load_pos      = load_sq_tail - head;  // Stores older than the load
        hit           = '0;
        load_fwd_data = '0;
        for (int k = 1; k <= SQ_DEPTH; k++) begin
            idx = load_sq_tail - idx_t'(k);
            age = idx - head;
            if (age < load_pos && valid[idx] && filled[idx] &&
                    entry_q[idx].word_addr == load_addr[31:2]) begin
                for (int l = 0; l < 4; l++) begin
                    if (entry_q[idx].strb[l] && !hit[l]) begin
                        load_fwd_data[8*l +: 8] = entry_q[idx].data[8*l +: 8];
                        hit[l] = 1'b1;
                    end
                end
            end
        end
        load_fwd_mask = hit;
    end

endmodule

// File: store_drain_axil.sv
`timescale 1ns/1ps

module store_drain_axil (
    input  logic               clock,
    input  logic               reset,

    input  logic               drain_valid,
    output logic               drain_ready,
    input  sq_pkg::sq_drain_t  drain,

    // AXI4-Lite write address
    output logic               awvalid,
    input  logic               awready,
    output sq_pkg::addr_t      awaddr,

    // AXI4-Lite write data
    output logic               wvalid,
    input  logic               wready,
    output sq_pkg::data_t      wdata,
    output sq_pkg::strb_t      wstrb,

    // AXI4-Lite write response
    input  logic               bvalid,
    output logic               bready,
    input  sq_pkg::axil_resp_e bresp,

    output logic               write_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR_DATA,
        ST_RESP
    } state_e;

    state_e            state;
    sq_pkg::sq_drain_t pkt;  // Store being written
    logic              aw_done;
    logic              w_done;

    assign drain_ready = state == ST_IDLE;

    assign awaddr = {pkt.word_addr, 2'b00};
    assign wdata  = pkt.data;
    assign wstrb  = pkt.strb;

    // Each channel done once its beat is taken, now or earlier
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ST_IDLE;
            awvalid     <= 1'b0;
            wvalid      <= 1'b0;
            bready      <= 1'b0;
            write_error <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (drain_valid) begin
                        awvalid <= 1'b1;  // AW and W go out together
                        wvalid  <= 1'b1;
                        state   <= ST_ADDR_DATA;
                    end
                end
                ST_ADDR_DATA: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) begin
                        bready <= 1'b1;
                        state  <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= ST_IDLE;
                        if (bresp == sq_pkg::SLVERR) begin
                            write_error <= 1'b1;  // Sticky
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (drain_valid && drain_ready) begin
            pkt <= drain;
        end
    end

endmodule

// File: store_subsystem.sv
`timescale 1ns/1ps

module store_subsystem #(
    parameter  int SQ_DEPTH = 8,
    localparam int IDX_W    = $clog2(SQ_DEPTH)
) (
    input  logic               clock,
    input  logic               reset,

    // Dispatch
    input  logic               dispatch_valid,
    output logic               dispatch_ready,
    output logic [IDX_W-1:0]   sq_tail,

    // Store execute
    input  logic               exec_valid,
    input  sq_pkg::st_exec_t   exec,

    // Retire and branch recovery
    input  logic               retire_valid,
    input  logic               restore_valid,
    input  logic [IDX_W-1:0]   restore_tail,

    // Load lookup
    input  sq_pkg::addr_t      load_addr,
    input  logic [IDX_W-1:0]   load_sq_tail,
    output sq_pkg::data_t      load_fwd_data,
    output sq_pkg::strb_t      load_fwd_mask,

    // AXI4-Lite write master
    output logic               awvalid,
    input  logic               awready,
    output sq_pkg::addr_t      awaddr,
    output logic               wvalid,
    input  logic               wready,
    output sq_pkg::data_t      wdata,
    output sq_pkg::strb_t      wstrb,
    input  logic               bvalid,
    output logic               bready,
    input  sq_pkg::axil_resp_e bresp,
    output logic               write_error
);

    logic              fill_valid;
    sq_pkg::sq_fill_t  fill;
    logic              drain_valid;
    logic              drain_ready;
    sq_pkg::sq_drain_t drain;

    store_agu agu0 (
        .clock      (clock),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec       (exec),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) sq0 (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .sq_tail        (sq_tail),
        .fill_valid     (fill_valid),
        .fill           (fill),
        .retire_valid   (retire_valid),
        .restore_valid  (restore_valid),
        .restore_tail   (restore_tail),
        .load_addr      (load_addr),
        .load_sq_tail   (load_sq_tail),
        .load_fwd_data  (load_fwd_data),
        .load_fwd_mask  (load_fwd_mask),
        .drain_valid    (drain_valid),
        .drain_ready    (drain_ready),
        .drain          (drain)
    );

    store_drain_axil drain0 (
        .clock       (clock),
        .reset       (reset),
        .drain_valid (drain_valid),
        .drain_ready (drain_ready),
        .drain       (drain),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .write_error (write_error)
    );

endmodule

// File: tb_axil_mem.sv
`timescale 1ns/1ps

module tb_axil_mem (
    input  logic               clock,
    input  logic               reset,
    input  logic               awvalid,
    output logic               awready,
    input  sq_pkg::addr_t      awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  sq_pkg::data_t      wdata,
    input  sq_pkg::strb_t      wstrb,
    output logic               bvalid,
    input  logic               bready,
    output sq_pkg::axil_resp_e bresp
);

    logic [31:0]   mem [16];          // Words 0x100 to 0x13c that the testbench reads
    int            write_count = 0;   // Completed B handshakes
    logic          aw_got;
    logic          w_got;
    sq_pkg::addr_t addr_q;
    sq_pkg::data_t data_q;
    sq_pkg::strb_t strb_q;

    assign bresp = sq_pkg::OKAY;

    initial begin
        awready <= 1'b0;  // Quiet before the first reset edge
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] <= '0;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            aw_got      <= 1'b0;
            w_got       <= 1'b0;
            write_count <= 0;
        end else begin
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                addr_q  <= awaddr;
                awready <= 1'b0;
            end else begin
                awready <= !aw_got && ($urandom_range(3) != 0);  // Random stall
            end
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                data_q <= wdata;
                strb_q <= wstrb;
                wready <= 1'b0;
            end else begin
                wready <= !w_got && ($urandom_range(3) != 0);
            end
            if (bvalid && bready) begin
                for (int l = 0; l < 4; l++) begin
                    if (strb_q[l]) mem[addr_q[5:2]][8*l +: 8] <= data_q[8*l +: 8];
                end
                bvalid      <= 1'b0;
                aw_got      <= 1'b0;
                w_got       <= 1'b0;
                write_count <= write_count + 1;
            end else if (aw_got && w_got && !bvalid) begin
                bvalid <= ($urandom_range(1) == 1);  // Response delay
            end
        end
    end

endmodule

// File: tb_store_subsystem.sv
`timescale 1ns/1ps

module tb_store_subsystem;

    typedef enum logic [3:0] {
        OP_DISP, OP_EXEC, OP_RETIRE, OP_RESTORE, OP_LOAD, OP_MEMCHK, OP_READY, OP_IDLE,
        OP_TEST, OP_NOWRITE
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [1:0]  e;
    } row_t;

    logic clock;
    logic reset;
    logic dispatch_valid, dispatch_ready, exec_valid, retire_valid, restore_valid;
    logic [2:0] sq_tail, restore_tail, load_sq_tail;
    sq_pkg::st_exec_t exec;
    sq_pkg::addr_t load_addr, awaddr;
    sq_pkg::data_t load_fwd_data, wdata;
    sq_pkg::strb_t load_fwd_mask, wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready, write_error;
    sq_pkg::axil_resp_e bresp;

    row_t rows[$];
    logic built = 1'b0;
    logic [2:0] exp_tail = '0;   // Tail value the next dispatch should get
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_base = 0;

    store_subsystem #(.SQ_DEPTH(8)) dut0 (.*);

    tb_axil_mem mem0 (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input op_e op, input logic [31:0] a = 0, input logic [31:0] b = 0,
                           input logic [31:0] c = 0, input logic [31:0] d = 0,
                           input logic [1:0] e = 0);
        rows.push_back('{op, a, b, c, d, e});
    endtask

    // Dispatch then execute the store into the entry just allocated
    task automatic add_store(input logic [31:0] base, input logic [31:0] off,
                             input logic [31:0] data, input logic [1:0] size);
        add_row(OP_DISP, exp_tail);
        add_row(OP_EXEC, exp_tail, base, off, data, size);
        exp_tail++;
    endtask

    task automatic build_table();
        logic [31:0] shadow;
        logic [1:0]  lane;
        logic [7:0]  val;
        // Test 1 reset state
        add_row(OP_READY, 1, 0);
        repeat (3) add_row(OP_NOWRITE);
        add_row(OP_MEMCHK, 32'h100, 0, 0);
        add_row(OP_TEST, 1);
        // Test 2 byte, half and word stores in order
        add_store(32'h100, 0, 32'h11223344, 2);
        add_store(32'h100, 1, 32'h000000ab, 0);
        add_store(32'h104, 2, 32'h0000beef, 1);
        add_store(32'h108, 3, 32'h0000cafe, 1);  // Half crossing the word keeps the top lane
        repeat (4) add_row(OP_RETIRE);
        add_row(OP_MEMCHK, 32'h100, 32'h1122ab44, 4);
        add_row(OP_MEMCHK, 32'h104, 32'hbeef0000, 4);
        add_row(OP_MEMCHK, 32'h108, 32'hfe000000, 4);
        add_row(OP_TEST, 2);
        // Test 3 forwarding from entries 4 to 6
        add_store(32'h10c, 0, 32'h01020304, 2);
        add_store(32'h10c, 1, 32'h0000aa55, 1);
        add_store(32'h10c, 0, 32'h00000077, 0);
        add_row(OP_IDLE);
        add_row(OP_LOAD, 32'h10c, 6, 32'h01aa5504, 4'hf);
        add_row(OP_LOAD, 32'h10c, 7, 32'h01aa5577, 4'hf);
        add_row(OP_LOAD, 32'h10c, 5, 32'h01020304, 4'hf);
        add_row(OP_LOAD, 32'h10e, 4, 0, 0);
        add_row(OP_LOAD, 32'h110, 7, 0, 0);
        repeat (3) add_row(OP_RETIRE);
        add_row(OP_MEMCHK, 32'h10c, 32'h01aa5577, 7);
        add_row(OP_TEST, 3);
        // Test 4 restore drops two younger stores
        add_store(32'h110, 0, 32'h12345678, 2);
        add_store(32'h114, 0, 32'hdeadbeef, 2);
        add_store(32'h118, 0, 32'hbad0bad0, 2);
        add_row(OP_RETIRE);
        add_row(OP_RESTORE, 0);
        exp_tail = 0;
        add_row(OP_READY, 1, 0);
        add_store(32'h114, 0, 32'h0000c0de, 2);
        add_row(OP_IDLE);
        add_row(OP_RETIRE);
        add_row(OP_MEMCHK, 32'h110, 32'h12345678, 8);
        add_row(OP_MEMCHK, 32'h114, 32'h0000c0de, 9);
        add_row(OP_MEMCHK, 32'h118, 0, 9);
        add_row(OP_TEST, 4);
        // Test 5 full queue
        for (int n = 1; n <= 8; n++) begin
            add_store((n % 2) ? 32'h120 : 32'h124, 0, 32'h50000000 + n, 2);
        end
        add_row(OP_READY, 0, 1);
        repeat (8) add_row(OP_RETIRE);
        add_row(OP_MEMCHK, 32'h120, 32'h50000007, 17);
        add_row(OP_MEMCHK, 32'h124, 32'h50000008, 17);
        add_row(OP_READY, 1, 1);
        add_row(OP_TEST, 5);
        // Test 6 random byte stores under AXI stalls
        shadow = '0;
        for (int n = 0; n < 8; n++) begin
            lane = 2'($urandom_range(3));
            val  = 8'($urandom_range(255));
            shadow[8*lane +: 8] = val;
            add_store(32'h128, {30'd0, lane}, {24'd0, val}, 0);
            add_row(OP_IDLE);
            add_row(OP_RETIRE);
        end
        add_row(OP_MEMCHK, 32'h128, shadow, 25);
        add_row(OP_TEST, 6);
    endtask

    task automatic apply_row(input row_t r);
        dispatch_valid = 1'b0;
        exec_valid     = 1'b0;
        retire_valid   = 1'b0;
        restore_valid  = 1'b0;
        case (r.op)
            OP_DISP: begin
                while (!dispatch_ready) @(negedge clock);
                check("sq_tail", sq_tail, r.a);
                dispatch_valid = 1'b1;
            end
            OP_EXEC: begin
                exec.index  = r.a[2:0];
                exec.base   = r.b;
                exec.offset = r.c;
                exec.data   = r.d;
                exec.size   = sq_pkg::st_size_e'(r.e);
                exec_valid  = 1'b1;
            end
            OP_RETIRE: retire_valid = 1'b1;
            OP_RESTORE: begin
                restore_tail  = r.a[2:0];
                restore_valid = 1'b1;
            end
            OP_LOAD: begin
                load_addr    = r.a;
                load_sq_tail = r.b[2:0];
                #1;
                check("load_fwd_data", load_fwd_data, r.c);
                check("load_fwd_mask", load_fwd_mask, r.d);
            end
            OP_MEMCHK: begin
                while (mem0.write_count < r.c) @(negedge clock);
                check("write count", mem0.write_count, r.c);
                check("memory word", mem0.mem[r.a[5:2]], r.b);
            end
            OP_READY: begin
                check("dispatch_ready", dispatch_ready, r.a);
                check("sq_tail", sq_tail, r.b);
            end
            OP_NOWRITE: begin
                check("awvalid", awvalid, 0);
                check("wvalid", wvalid, 0);
            end
            OP_TEST: begin
                tests++;
                $display("Test %0d: %s (%0d errors)", r.a,
                         (errors == test_base) ? "pass" : "fail", errors - test_base);
                test_base = errors;
            end
            default: ;
        endcase
        @(negedge clock);
    endtask

    // Every write lands word aligned inside the modelled window
    always @(negedge clock) begin
        if (!reset && awvalid && awready) begin
            check("awaddr window", awaddr & 32'hffffffc3, 32'h100);
        end
    end

    initial begin
        void'($urandom(32'h15f06c42));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        exec_valid     = 1'b0;
        exec           = '0;
        retire_valid   = 1'b0;
        restore_valid  = 1'b0;
        restore_tail   = '0;
        load_addr      = '0;
        load_sq_tail   = '0;
        build_table();
        built = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        check("write_error", write_error, 0);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog allows 50 cycles per table row
    initial begin
        wait (built);
        repeat (rows.size() * 50) @(posedge clock);
        $display("Timeout: the table did not finish within %0d cycles", rows.size() * 50);
        $display("Errors found");
        $finish;
    end

endmodule

// File: store_subsystem.f
sq_pkg.sv
store_agu.sv
store_queue.sv
store_drain_axil.sv
store_subsystem.sv
tb_axil_mem.sv
tb_store_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_store_subsystem
FILELIST  ?= store_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
